// File: ro_mem_pkg.sv
`default_nettype none

package ro_mem_pkg;

   localparam int WORD_BITS  = 32;
   localparam int LINE_WORDS = 16;
   localparam int LINE_BITS  = WORD_BITS * LINE_WORDS;
   localparam int ADDR_BITS  = 32;
   localparam int N_TAGS     = 8;
   localparam int N_THREADS  = 8;

   typedef logic [$clog2(N_TAGS)-1:0]    tag_t;
   typedef logic [$clog2(N_THREADS)-1:0] thread_t;
   typedef logic [LINE_WORDS-1:0]        word_mask_t;
   typedef logic [7:0]                   word_count_t;

   // configuration strobe addresses, write only
   typedef logic [7:0] cfg_addr_t;
   localparam cfg_addr_t OFFSET_BASE_ADDR   = 8'h10;
   localparam cfg_addr_t NEIGHBOR_BASE_ADDR = 8'h14;

   // items minus one -> words, every item is 64 bits
   function automatic word_count_t burst_words(word_count_t len);
      return word_count_t'({len, 1'b0} + 9'd2);
   endfunction

endpackage

`default_nettype wire

// File: ro_task_pkg.sv
`default_nettype none

package ro_task_pkg;

   localparam int N_SUBTYPES = 3;

   typedef logic [1:0] subtype_t;

   localparam subtype_t SUB_VERTEX = 2'd0;
   localparam subtype_t SUB_RANGE  = 2'd1;
   localparam subtype_t SUB_RELAX  = 2'd2;

   typedef struct packed {
      logic [31:0] ts;
      logic [31:0] locale;
   } task_t;

   // subtype 1 view: pair of offsets into the neighbor table
   typedef struct packed {
      logic [31:0] end_off;
      logic [31:0] start_off;
   } range_t;

   // subtype 2 view: one neighbor record
   typedef struct packed {
      logic [31:0] weight;
      logic [31:0] neighbor;
   } edge_t;

   typedef union packed {
      range_t offsets;
      edge_t  link;
   } task_data_u;

endpackage

`default_nettype wire

// File: free_list.sv
`default_nettype none

module free_list #(
   parameter int LOG_DEPTH = 3
) (
   input  wire                  clk,
   input  wire                  rstn,
   input  wire                  wr_en,
   input  wire [LOG_DEPTH-1:0]  wr_data,
   input  wire                  rd_en,
   output logic [LOG_DEPTH-1:0] rd_data,
   output logic                 empty,
   output logic                 full
);

   logic [LOG_DEPTH-1:0] slots [2**LOG_DEPTH];
   logic [LOG_DEPTH-1:0] rd_ptr;
   logic [LOG_DEPTH-1:0] wr_ptr;
   logic [LOG_DEPTH:0]   count;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count <= {1'b1, {LOG_DEPTH{1'b0}}};  // every index present
         for (int i = 0; i < 2**LOG_DEPTH; i++) begin
            slots[i] <= i[LOG_DEPTH-1:0];
         end
      end else begin
         if (wr_en) begin
            slots[wr_ptr] <= wr_data;
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         if (wr_en & !rd_en) count <= count + 1'b1;
         else if (rd_en & !wr_en) count <= count - 1'b1;
      end
   end

   assign rd_data = slots[rd_ptr];
   assign empty = (count == '0);
   assign full = count[LOG_DEPTH];

endmodule

`default_nettype wire

// File: subtype_arbiter.sv
`default_nettype none

module subtype_arbiter (
   input  wire [ro_task_pkg::N_SUBTYPES-1:0]                        task_in_valid,
   output logic [ro_task_pkg::N_SUBTYPES-1:0]                       task_in_ready,
   input  wire ro_task_pkg::task_t [ro_task_pkg::N_SUBTYPES-1:0]     in_task,
   input  wire ro_task_pkg::task_data_u [ro_task_pkg::N_SUBTYPES-1:0] in_data,
   input  wire [ro_task_pkg::N_SUBTYPES-1:0]                        in_last,

   output logic                   grant_valid,
   input  wire                    grant_ready,
   output ro_task_pkg::task_t     grant_task,
   output ro_task_pkg::task_data_u grant_data,
   output ro_task_pkg::subtype_t  grant_subtype,
   output logic                   grant_last
);
   import ro_task_pkg::*;

   always_comb begin
      grant_valid = 1'b0;
      grant_subtype = SUB_VERTEX;
      for (int i = 0; i < N_SUBTYPES; i++) begin
         if (task_in_valid[i]) begin  // later hits win, so highest subtype
            grant_valid = 1'b1;
            grant_subtype = subtype_t'(i);
         end
      end
      grant_task = in_task[grant_subtype];
      grant_data = in_data[grant_subtype];
      grant_last = in_last[grant_subtype];
      task_in_ready = '0;
      task_in_ready[grant_subtype] = grant_valid & grant_ready;
   end

endmodule

`default_nettype wire

// File: sssp_worker.sv
`default_nettype none

module sssp_worker (
   input  wire                      clk,
   input  wire                      rstn,

   input  wire                      grant_valid,
   output logic                     grant_ready,
   input  wire ro_task_pkg::task_t   grant_task,
   input  wire ro_task_pkg::task_data_u grant_data,
   input  wire ro_task_pkg::subtype_t grant_subtype,
   input  wire                      grant_last,

   input  wire                      cfg_wvalid,
   input  wire ro_mem_pkg::cfg_addr_t cfg_waddr,
   input  wire [ro_mem_pkg::WORD_BITS-1:0] cfg_wdata,

   output logic                     req_valid,
   input  wire                      req_ready,
   output logic [ro_mem_pkg::ADDR_BITS-1:0] req_addr,
   output ro_mem_pkg::word_count_t  req_len,
   output ro_task_pkg::task_t       resp_task,
   output ro_task_pkg::subtype_t    resp_subtype,
   output logic                     resp_mark_last,

   output logic                     child_valid,
   input  wire                      child_ready,
   output ro_task_pkg::task_t       child_task
);
   import ro_mem_pkg::*;
   import ro_task_pkg::*;

   logic [ADDR_BITS-1:0] offset_base;
   logic [ADDR_BITS-1:0] neighbor_base;
   logic [WORD_BITS-1:0] n_items;
   logic                 child_out_valid;
   logic                 child_out_ready;
   task_t                child_out_task;

   assign resp_task = grant_task;  // every response pair becomes a task carrying this
   assign n_items = grant_data.offsets.end_off - grant_data.offsets.start_off;
   assign child_out_ready = !child_valid | child_ready;

   always_comb begin
      req_valid = 1'b0;
      req_addr = offset_base + (grant_task.locale << 2);
      req_len = '0;
      resp_subtype = SUB_RANGE;
      resp_mark_last = 1'b0;
      child_out_valid = 1'b0;
      child_out_task.locale = grant_data.link.neighbor;
      child_out_task.ts = grant_task.ts + grant_data.link.weight;
      case (grant_subtype)
         SUB_VERTEX: req_valid = grant_valid;  // offset[L] and offset[L+1]
         SUB_RANGE: begin
            req_valid = grant_valid & (n_items != '0);  // empty range retires here
            req_addr = neighbor_base + (grant_data.offsets.start_off << 3);
            req_len = word_count_t'(n_items - 1);
            resp_subtype = SUB_RELAX;
            resp_mark_last = grant_last;
         end
         SUB_RELAX: child_out_valid = grant_valid;
         default: ;
      endcase
      grant_ready = (!req_valid | req_ready) & (!child_out_valid | child_out_ready);
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         offset_base <= '0;
         neighbor_base <= '0;
      end else if (cfg_wvalid) begin
         case (cfg_waddr)
            OFFSET_BASE_ADDR:   offset_base <= cfg_wdata << 2;  // word index to bytes
            NEIGHBOR_BASE_ADDR: neighbor_base <= cfg_wdata << 2;
            default: ;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         child_valid <= 1'b0;
      end else if (child_out_valid & child_out_ready) begin
         child_valid <= 1'b1;
      end else if (child_ready) begin
         child_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (child_out_valid & child_out_ready) begin
         child_task <= child_out_task;
      end
   end

endmodule

`default_nettype wire

// File: read_issuer.sv
`default_nettype none

module read_issuer (
   input  wire                      clk,
   input  wire                      rstn,

   input  wire                      req_valid,
   output logic                     req_ready,
   input  wire [ro_mem_pkg::ADDR_BITS-1:0] req_addr,
   input  wire ro_mem_pkg::word_count_t req_len,
   input  wire ro_mem_pkg::thread_t new_thread,
   input  wire                      thread_empty,

   output logic                     arvalid,
   input  wire                      arready,
   output logic [ro_mem_pkg::ADDR_BITS-1:0] araddr,
   output ro_mem_pkg::tag_t         arid,

   input  wire                      rvalid,
   input  wire                      rready,
   input  wire ro_mem_pkg::tag_t     rid,
   output ro_mem_pkg::thread_t      tag_thread,
   output ro_mem_pkg::word_mask_t   tag_mask
);
   import ro_mem_pkg::*;

   logic                 busy;
   logic [ADDR_BITS-1:0] cur_addr;
   word_count_t          words_left;
   thread_t              cur_thread;
   logic [4:0]           room;
   logic [4:0]           piece_words;
   logic                 last_piece;
   word_mask_t           piece_mask;
   logic                 tag_empty;
   logic                 ar_fire;
   logic                 req_fire;
   thread_t              tag_thread_mem [N_TAGS];
   word_mask_t           tag_mask_mem [N_TAGS];

   // words until the end of the current 64-byte line
   assign room = 5'(LINE_WORDS) - {1'b0, cur_addr[5:2]};
   assign last_piece = (words_left <= {3'b000, room});
   assign piece_words = last_piece ? words_left[4:0] : room;

   always_comb begin
      for (int i = 0; i < LINE_WORDS; i++) begin
         piece_mask[i] = (5'(i) >= {1'b0, cur_addr[5:2]}) &&
                         (5'(i) < ({1'b0, cur_addr[5:2]} + piece_words));
      end
   end

   assign arvalid = busy & !tag_empty;
   assign araddr = cur_addr;
   assign ar_fire = arvalid & arready;
   assign req_ready = !thread_empty & (!busy | (ar_fire & last_piece));
   assign req_fire = req_valid & req_ready;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         busy <= 1'b0;
      end else if (req_fire) begin
         busy <= 1'b1;
      end else if (ar_fire & last_piece) begin
         busy <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (req_fire) begin
         cur_addr <= req_addr;
         words_left <= burst_words(req_len);
         cur_thread <= new_thread;
      end else if (ar_fire) begin
         cur_addr <= cur_addr + ADDR_BITS'({piece_words, 2'b00});  // next piece is line aligned
         words_left <= words_left - word_count_t'(piece_words);
      end
   end

   always_ff @(posedge clk) begin
      if (ar_fire) begin
         tag_thread_mem[arid] <= cur_thread;
         tag_mask_mem[arid] <= piece_mask;
      end
   end

   // looked up while rvalid is up, registered by the unpacker
   assign tag_thread = tag_thread_mem[rid];
   assign tag_mask = tag_mask_mem[rid];

   free_list #(
      .LOG_DEPTH($clog2(N_TAGS))
   ) tag_list (
      .clk     (clk),
      .rstn    (rstn),
      .wr_en   (rvalid & rready),
      .wr_data (rid),
      .rd_en   (ar_fire),
      .rd_data (arid),
      .empty   (tag_empty),
      .full    ()
   );

endmodule

`default_nettype wire

// File: resp_unpacker.sv
`default_nettype none

module resp_unpacker (
   input  wire                      clk,
   input  wire                      rstn,

   input  wire                      accept_valid,
   input  wire ro_mem_pkg::thread_t  accept_thread,
   input  wire ro_task_pkg::task_t   resp_task,
   input  wire ro_task_pkg::subtype_t resp_subtype,
   input  wire                      resp_mark_last,
   input  wire ro_mem_pkg::word_count_t req_len,

   input  wire                      rvalid,
   output logic                     rready,
   input  wire [ro_mem_pkg::LINE_BITS-1:0] rdata,
   input  wire ro_mem_pkg::thread_t  tag_thread,
   input  wire ro_mem_pkg::word_mask_t tag_mask,

   output logic                     out_valid,
   input  wire                      out_ready,
   output ro_task_pkg::task_t       out_task,
   output ro_task_pkg::subtype_t    out_subtype,
   output ro_task_pkg::task_data_u  out_data,
   output logic                     out_last,

   output logic                     thread_free_valid,
   output ro_mem_pkg::thread_t      thread_free
);
   import ro_mem_pkg::*;
   import ro_task_pkg::*;

   // per thread context
   task_t                ctx_task [N_THREADS];
   subtype_t             ctx_subtype [N_THREADS];
   logic                 ctx_mark_last [N_THREADS];
   word_count_t          remaining [N_THREADS];
   logic [WORD_BITS-1:0] saved_word [N_THREADS];  // lone word of a straddling pair

   logic                 beat_valid;
   logic [LINE_BITS-1:0] beat_data;
   thread_t              beat_thread;
   word_mask_t           beat_mask;
   word_mask_t           next_mask;
   logic [3:0]           word_id;
   logic [3:0]           word_id_nx;
   logic [WORD_BITS-1:0] word_lo;
   logic [WORD_BITS-1:0] word_hi;
   word_count_t          rem;
   logic                 pair;
   logic                 is_last;
   logic                 emit;
   logic                 advance;

   always_comb begin
      word_id = '0;
      for (int i = LINE_WORDS - 1; i >= 0; i--) begin
         if (beat_mask[i]) word_id = i[3:0];  // lowest valid word
      end
   end

   assign word_id_nx = word_id + 4'd1;
   assign word_lo = beat_data[word_id * WORD_BITS +: WORD_BITS];
   assign word_hi = beat_data[word_id_nx * WORD_BITS +: WORD_BITS];
   assign rem = remaining[beat_thread];

   assign pair = !rem[0] & (word_id != 4'(LINE_WORDS - 1)) & beat_mask[word_id_nx];
   assign is_last = pair ? (rem == 8'd2) : (rem == 8'd1);
   assign emit = pair | rem[0];  // an odd count left means a saved word waits for this one
   assign advance = beat_valid & (!emit | out_ready);

   assign rready = !beat_valid;
   assign out_valid = beat_valid & emit;
   assign out_task = ctx_task[beat_thread];
   assign out_subtype = ctx_subtype[beat_thread];
   assign out_last = is_last & ctx_mark_last[beat_thread];
   assign thread_free_valid = out_valid & out_ready & is_last;
   assign thread_free = beat_thread;

   always_comb begin
      if (pair) begin
         out_data = task_data_u'({word_hi, word_lo});
      end else if (word_id == '0) begin
         out_data = task_data_u'({word_lo, saved_word[beat_thread]});  // low half came earlier
      end else begin
         out_data = task_data_u'({saved_word[beat_thread], word_lo});
      end
   end

   always_comb begin
      next_mask = beat_mask;
      next_mask[word_id] = 1'b0;
      if (pair) next_mask[word_id_nx] = 1'b0;
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         beat_valid <= 1'b0;
      end else if (rvalid & rready) begin
         beat_valid <= 1'b1;
      end else if (advance & (next_mask == '0)) begin
         beat_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (rvalid & rready) begin
         beat_data <= rdata;
         beat_thread <= tag_thread;
         beat_mask <= tag_mask;
      end else if (advance) begin
         beat_mask <= next_mask;
      end
      if (advance & !pair) begin
         saved_word[beat_thread] <= word_lo;
      end
   end

   always_ff @(posedge clk) begin
      if (accept_valid) begin
         ctx_task[accept_thread] <= resp_task;
         ctx_subtype[accept_thread] <= resp_subtype;
         ctx_mark_last[accept_thread] <= resp_mark_last;
         remaining[accept_thread] <= burst_words(req_len);
      end
      if (advance) begin  // never the thread just accepted, it has no reads yet
         remaining[beat_thread] <= rem - (pair ? 8'd2 : 8'd1);
      end
   end

endmodule

`default_nettype wire

// File: read_only_stage.sv
`default_nettype none

module read_only_stage (
   input  wire                      clk,
   input  wire                      rstn,

   input  wire [ro_task_pkg::N_SUBTYPES-1:0]                         task_in_valid,
   output logic [ro_task_pkg::N_SUBTYPES-1:0]                        task_in_ready,
   input  wire ro_task_pkg::task_t [ro_task_pkg::N_SUBTYPES-1:0]      in_task,
   input  wire ro_task_pkg::task_data_u [ro_task_pkg::N_SUBTYPES-1:0] in_data,
   input  wire [ro_task_pkg::N_SUBTYPES-1:0]                         in_last,

   input  wire                      cfg_wvalid,
   input  wire ro_mem_pkg::cfg_addr_t cfg_waddr,
   input  wire [ro_mem_pkg::WORD_BITS-1:0] cfg_wdata,

   output logic                     arvalid,
   input  wire                      arready,
   output logic [ro_mem_pkg::ADDR_BITS-1:0] araddr,
   output ro_mem_pkg::tag_t         arid,

   input  wire                      rvalid,
   output logic                     rready,
   input  wire ro_mem_pkg::tag_t     rid,
   input  wire [ro_mem_pkg::LINE_BITS-1:0] rdata,

   output logic                     out_valid,
   input  wire                      out_ready,
   output ro_task_pkg::task_t       out_task,
   output ro_task_pkg::subtype_t    out_subtype,
   output ro_task_pkg::task_data_u  out_data,
   output logic                     out_last,

   output logic                     child_valid,
   input  wire                      child_ready,
   output ro_task_pkg::task_t       child_task,

   output logic                     idle  // every thread back in the free list
);
   import ro_mem_pkg::*;
   import ro_task_pkg::*;

   logic                 grant_valid;
   logic                 grant_ready;
   task_t                grant_task;
   task_data_u           grant_data;
   subtype_t             grant_subtype;
   logic                 grant_last;

   logic                 req_valid;
   logic                 req_ready;
   logic [ADDR_BITS-1:0] req_addr;
   word_count_t          req_len;
   task_t                resp_task;
   subtype_t             resp_subtype;
   logic                 resp_mark_last;

   thread_t              new_thread;
   logic                 thread_empty;
   thread_t              tag_thread;
   word_mask_t           tag_mask;
   logic                 thread_free_valid;
   thread_t              thread_free;

   subtype_arbiter arbiter (
      .task_in_valid (task_in_valid),
      .task_in_ready (task_in_ready),
      .in_task       (in_task),
      .in_data       (in_data),
      .in_last       (in_last),
      .grant_valid   (grant_valid),
      .grant_ready   (grant_ready),
      .grant_task    (grant_task),
      .grant_data    (grant_data),
      .grant_subtype (grant_subtype),
      .grant_last    (grant_last)
   );

   sssp_worker worker (
      .clk            (clk),
      .rstn           (rstn),
      .grant_valid    (grant_valid),
      .grant_ready    (grant_ready),
      .grant_task     (grant_task),
      .grant_data     (grant_data),
      .grant_subtype  (grant_subtype),
      .grant_last     (grant_last),
      .cfg_wvalid     (cfg_wvalid),
      .cfg_waddr      (cfg_waddr),
      .cfg_wdata      (cfg_wdata),
      .req_valid      (req_valid),
      .req_ready      (req_ready),
      .req_addr       (req_addr),
      .req_len        (req_len),
      .resp_task      (resp_task),
      .resp_subtype   (resp_subtype),
      .resp_mark_last (resp_mark_last),
      .child_valid    (child_valid),
      .child_ready    (child_ready),
      .child_task     (child_task)
   );

   read_issuer issuer (
      .clk          (clk),
      .rstn         (rstn),
      .req_valid    (req_valid),
      .req_ready    (req_ready),
      .req_addr     (req_addr),
      .req_len      (req_len),
      .new_thread   (new_thread),
      .thread_empty (thread_empty),
      .arvalid      (arvalid),
      .arready      (arready),
      .araddr       (araddr),
      .arid         (arid),
      .rvalid       (rvalid),
      .rready       (rready),
      .rid          (rid),
      .tag_thread   (tag_thread),
      .tag_mask     (tag_mask)
   );

   resp_unpacker unpacker (
      .clk               (clk),
      .rstn              (rstn),
      .accept_valid      (req_valid & req_ready),
      .accept_thread     (new_thread),
      .resp_task         (resp_task),
      .resp_subtype      (resp_subtype),
      .resp_mark_last    (resp_mark_last),
      .req_len           (req_len),
      .rvalid            (rvalid),
      .rready            (rready),
      .rdata             (rdata),
      .tag_thread        (tag_thread),
      .tag_mask          (tag_mask),
      .out_valid         (out_valid),
      .out_ready         (out_ready),
      .out_task          (out_task),
      .out_subtype       (out_subtype),
      .out_data          (out_data),
      .out_last          (out_last),
      .thread_free_valid (thread_free_valid),
      .thread_free       (thread_free)
   );

   // one thread per accepted read, returned by its last pair
   free_list #(
      .LOG_DEPTH($clog2(N_THREADS))
   ) thread_list (
      .clk     (clk),
      .rstn    (rstn),
      .wr_en   (thread_free_valid),
      .wr_data (thread_free),
      .rd_en   (req_valid & req_ready),
      .rd_data (new_thread),
      .empty   (thread_empty),
      .full    (idle)
   );

endmodule

`default_nettype wire

// File: ro_stage_checker.sv
`default_nettype none

module ro_stage_checker (
   input wire        clk,
   input wire        rstn,
   input wire        arvalid,
   input wire        arready,
   input wire [31:0] araddr,
   input wire        child_valid,
   input wire        child_ready,
   input wire        out_valid,
   input wire        idle
);

   ar_hold: assert property (@(posedge clk) disable iff (!rstn)
      arvalid && !arready |=> arvalid && $stable(araddr))
      else $error("arvalid or araddr changed before arready");

   child_hold: assert property (@(posedge clk) disable iff (!rstn)
      child_valid && !child_ready |=> child_valid)
      else $error("child_valid dropped before child_ready");

   // no thread busy means nothing can be in flight
   idle_quiet: assert property (@(posedge clk) disable iff (!rstn)
      idle |-> !out_valid)
      else $error("out_valid high while idle");

endmodule

bind read_only_stage ro_stage_checker chk (.*);

`default_nettype wire

// File: tb_read_only_stage.sv
`default_nettype none

module tb_read_only_stage;
   import ro_mem_pkg::*;
   import ro_task_pkg::*;

   localparam int OB = 67;   // odd word bases so pairs straddle lines
   localparam int NB = 257;
   localparam int N_VERTEX = 40;
   localparam int N_RANGE = 40;
   localparam int N_EMPTY = 8;
   localparam int N_RELAX = 40;
   localparam int N_MIX = 30;
   localparam int WATCHDOG =
      (N_VERTEX + N_RANGE + N_EMPTY + N_RELAX + 3 * N_MIX) * 300 * 10 + 1000;

   logic clk;
   logic rstn;
   logic [2:0] task_in_valid;
   logic [2:0] task_in_ready;
   task_t [2:0] in_task;
   task_data_u [2:0] in_data;
   logic [2:0] in_last;
   logic cfg_wvalid;
   cfg_addr_t cfg_waddr;
   logic [31:0] cfg_wdata;
   logic arvalid;
   logic arready;
   logic [31:0] araddr;
   tag_t arid;
   logic rvalid;
   logic rready;
   tag_t rid;
   logic [LINE_BITS-1:0] rdata;
   logic out_valid;
   logic out_ready;
   task_t out_task;
   subtype_t out_subtype;
   task_data_u out_data;
   logic out_last;
   logic child_valid;
   logic child_ready;
   task_t child_task;
   logic idle;

   logic [31:0] lfsr = 32'hd833;
   logic [31:0] mem [1024];
   logic [128:0] lane_q [3][$];  // {task, data, last}
   logic [130:0] out_exp [$];     // {subtype, task, data, last}
   logic [63:0] child_exp [$];
   logic [34:0] ar_q [$];         // {id, addr}
   int errors = 0;
   int tests = 0;

   read_only_stage dut (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   initial begin
      #(WATCHDOG);
      $display("Error: watchdog expired, the DUT stopped making progress");
      $display("Simulation failed");
      $finish;
   end

   function automatic logic [31:0] rand_bits(int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h80200003 : 32'h0);
         r = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   function automatic void add_expect(int sub, logic [128:0] e);
      task_t t;
      logic [31:0] lo;
      logic [31:0] hi;
      t = e[128:65];
      lo = e[32:1];
      hi = e[64:33];
      case (sub)
         0: out_exp.push_back({SUB_RANGE, t, mem[OB + t.locale + 1], mem[OB + t.locale], 1'b0});
         1: for (int i = lo; i < hi; i++) begin
            out_exp.push_back({SUB_RELAX, t, mem[NB + 2 * i + 1], mem[NB + 2 * i],
                               e[0] && (i == hi - 1)});
         end
         default: child_exp.push_back({t.ts + hi, lo});
      endcase
   endfunction

   function automatic void queue_task(int sub, logic [63:0] t, logic [63:0] d, logic last);
      lane_q[sub].push_back({t, d, last});
      add_expect(sub, {t, d, last});
   endfunction

   function automatic void check_out();
      logic [130:0] got;
      int idx;
      got = {out_subtype, out_task, out_data, out_last};
      idx = -1;
      foreach (out_exp[i]) if (idx < 0 && out_exp[i] == got) idx = i;
      assert (idx >= 0) else begin
         $display("Error: unexpected out_subtype=%h out_task=%h out_data=%h out_last=%h",
                  out_subtype, out_task, out_data, out_last);
         errors++;
      end
      if (idx >= 0) out_exp.delete(idx);
   endfunction

   function automatic void check_child();
      int idx;
      idx = -1;
      foreach (child_exp[i]) if (idx < 0 && child_exp[i] == child_task) idx = i;
      assert (idx >= 0) else begin
         $display("Error: unexpected child_task=%h", child_task);
         errors++;
      end
      if (idx >= 0) child_exp.delete(idx);
   endfunction

   // memory, read responses and output sinks
   always begin
      logic ar_f;
      logic r_f;
      logic [34:0] ar_e;
      logic [31:0] base;
      @(negedge clk);
      ar_f = arvalid & arready;
      ar_e = {arid, araddr};
      r_f = rvalid & rready;
      if (out_valid && out_ready) check_out();
      if (child_valid && child_ready) check_child();
      @(posedge clk);
      #1;
      if (ar_f) ar_q.push_back(ar_e);
      if (r_f) begin
         void'(ar_q.pop_front());
         rvalid = 1'b0;
      end
      if (!rvalid && ar_q.size() > 0 && rand_bits(1) == 1) begin
         rvalid = 1'b1;
         rid = ar_q[0][34:32];
         base = (ar_q[0][31:0] >> 2) & ~32'hf;  // whole line, the issuer mask picks words
         for (int w = 0; w < LINE_WORDS; w++) rdata[w * 32 +: 32] = mem[(base + w) % 1024];
      end
      arready = rand_bits(2) != 0;
      out_ready = rand_bits(2) != 0;
      child_ready = rand_bits(1) == 1;
   end

   task automatic run_lanes();
      logic [2:0] hi;
      while (lane_q[0].size() + lane_q[1].size() + lane_q[2].size() > 0) begin
         @(posedge clk);
         #1;
         for (int l = 0; l < 3; l++) begin
            task_in_valid[l] = lane_q[l].size() > 0 && rand_bits(2) != 0;
            if (lane_q[l].size() > 0) begin
               in_task[l] = lane_q[l][0][128:65];
               in_data[l] = task_data_u'(lane_q[l][0][64:1]);
               in_last[l] = lane_q[l][0][0];
            end
         end
         @(negedge clk);
         hi = '0;
         for (int l = 0; l < 3; l++) if (task_in_valid[l]) hi = 3'(1 << l);
         assert ((task_in_ready & ~hi) == 0) else begin
            $display("Error: task_in_ready = %h with task_in_valid = %h",
                     task_in_ready, task_in_valid);
            errors++;
         end
         for (int l = 0; l < 3; l++) begin
            if (task_in_valid[l] && task_in_ready[l]) void'(lane_q[l].pop_front());
         end
      end
      @(posedge clk);
      #1;
      task_in_valid = '0;
   endtask

   task automatic finish_test(string name, int start_errors);
      while (out_exp.size() != 0 || child_exp.size() != 0 || child_valid) begin
         @(negedge clk);
      end
      repeat (3) @(negedge clk);  // last output consumed, its thread is back by now
      assert (idle) else begin
         $display("Error: idle = %h, expected 1", idle);
         errors++;
      end
      tests++;
      $display("test %s: %0d errors", name, errors - start_errors);
   endtask

   task automatic write_cfg(cfg_addr_t a, logic [31:0] d);
      @(posedge clk);
      #1;
      cfg_wvalid = 1'b1;
      cfg_waddr = a;
      cfg_wdata = d;
      @(posedge clk);
      #1;
      cfg_wvalid = 1'b0;
   endtask

   initial begin
      int e0;
      logic [31:0] v;
      logic [31:0] s;
      rstn = 1'b0;
      task_in_valid = '0;
      in_task = '0;
      in_data = '0;
      in_last = '0;
      cfg_wvalid = 1'b0;
      cfg_waddr = '0;
      cfg_wdata = '0;
      arready = 1'b0;
      rvalid = 1'b0;
      rid = '0;
      rdata = '0;
      out_ready = 1'b0;
      child_ready = 1'b0;
      for (int a = 0; a < 1024; a++) mem[a] = (a * 32'h9e3779b1) ^ 32'h5a5a0000;
      mem[OB] = 0;
      for (int i = 0; i < 32; i++) mem[OB + i + 1] = mem[OB + i] + rand_bits(2);
      for (int i = 0; i < 128; i++) begin
         mem[NB + 2 * i] = rand_bits(5);      // neighbor
         mem[NB + 2 * i + 1] = rand_bits(8);  // weight
      end
      repeat (5) @(posedge clk);
      #1;
      rstn = 1'b1;
      @(negedge clk);
      assert (idle) else begin
         $display("Error: idle = %h after reset, expected 1", idle);
         errors++;
      end
      write_cfg(OFFSET_BASE_ADDR, OB);
      write_cfg(NEIGHBOR_BASE_ADDR, NB);

      e0 = errors;
      for (int i = 0; i < N_VERTEX; i++) queue_task(0, {rand_bits(16), rand_bits(5)}, '0, 1'b0);
      run_lanes();
      finish_test("vertex", e0);

      e0 = errors;
      for (int i = 0; i < N_RANGE; i++) begin
         if (i % 2 == 0) begin
            v = rand_bits(5);
            queue_task(1, {rand_bits(16), v}, {mem[OB + v + 1], mem[OB + v]}, rand_bits(1));
         end else begin
            s = rand_bits(6);
            queue_task(1, {rand_bits(16), rand_bits(5)}, {s + 1 + rand_bits(4), s},
                       rand_bits(1));
         end
      end
      run_lanes();
      finish_test("range", e0);

      e0 = errors;
      for (int i = 0; i < N_EMPTY; i++) begin
         s = rand_bits(6);
         queue_task(1, {rand_bits(16), rand_bits(5)}, {s, s}, 1'b1);
      end
      run_lanes();
      finish_test("empty_range", e0);

      e0 = errors;
      for (int i = 0; i < N_RELAX; i++) begin
         queue_task(2, {rand_bits(16), rand_bits(5)}, {rand_bits(8), rand_bits(5)}, 1'b0);
      end
      run_lanes();
      finish_test("relax", e0);

      e0 = errors;
      for (int i = 0; i < N_MIX; i++) begin
         v = rand_bits(5);
         queue_task(0, {rand_bits(16), v}, '0, 1'b0);
         queue_task(1, {rand_bits(16), v}, {mem[OB + v + 1], mem[OB + v]}, rand_bits(1));
         queue_task(2, {rand_bits(16), v}, {rand_bits(8), rand_bits(5)}, 1'b0);
      end
      run_lanes();
      finish_test("mixed", e0);

      $display("tests run: %0d, errors: %0d", tests, errors);
      if (errors == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: verilog.f
ro_mem_pkg.sv
ro_task_pkg.sv
free_list.sv
subtype_arbiter.sv
sssp_worker.sv
read_issuer.sv
resp_unpacker.sv
read_only_stage.sv
ro_stage_checker.sv
tb_read_only_stage.sv

// File: run.sh
#!/bin/sh
# build and run with Verilator, pass only if the pass message shows up
verilator --binary --timing --assert -Wno-fatal -f verilog.f \
   --top-module tb_read_only_stage -o sim_ro \
   && ./obj_dir/sim_ro | tee /dev/stderr | grep -q "Simulation passed" \
   && echo "PASS" || { echo "FAIL"; exit 1; }
